/* include/i2c_cfg.svh */
`ifndef I2C_CFG_SVH
`define I2C_CFG_SVH

// clock cycles per quarter of an SCL period
`define I2C_CLK_DIV 4

// longest transaction the controller will run, in data bytes
`define I2C_MAX_BYTES 4

// width of the host data word
`define I2C_DATA_W 32

`endif

/* design/i2c_pkg.sv */
`include "i2c_cfg.svh"

package i2c_pkg;

  // host command, sampled with the start strobe
  typedef struct packed {
    logic                   rw;        // 1 means read
    logic [6:0]             dev_addr;
    logic [2:0]             nbytes;
    logic [`I2C_DATA_W-1:0] wdata;
  } i2c_cmd_t;

  typedef struct packed {
    logic                   rw;
    logic [7:0]             addr_byte;
    logic [2:0]             nbytes;
    logic [`I2C_DATA_W-1:0] wbytes;    // first byte on the wire sits in the top byte
  } i2c_job_t;

  // one per finished byte, plus a closing one once STOP is on the bus
  typedef struct packed {
    logic [7:0] data;
    logic       last;
    logic       nack;
    logic       is_read;
    logic       stop_done;
  } i2c_byte_evt_t;

  typedef struct packed {
    logic [`I2C_DATA_W-1:0] rdata;
    logic                   nack;
  } i2c_result_t;

endpackage

/* design/i2c_cmd_decode.sv */
`timescale 1ns/1ns
`include "i2c_cfg.svh"

module i2c_cmd_decode import i2c_pkg::*; (
  input  logic     rst,
  input  logic     clk,
  input  logic     start,
  input  i2c_cmd_t cmd,
  input  logic     done,
  output logic     busy,
  output logic     job_valid,
  output i2c_job_t job
);

  logic       busy_q;
  logic       accept;
  logic [2:0] nb;
  logic [5:0] shift;

  assign busy   = busy_q & ~done;  // drops in the same cycle as done
  assign accept = start & ~busy;

  // byte count is forced into 1..max before the data gets aligned
  always_comb begin
    if (cmd.nbytes == 3'd0) begin
      nb = 3'd1;
    end else if (cmd.nbytes > 3'(`I2C_MAX_BYTES)) begin
      nb = 3'(`I2C_MAX_BYTES);
    end else begin
      nb = cmd.nbytes;
    end
    shift = {3'(`I2C_MAX_BYTES) - nb, 3'b000};
  end

  always_ff @(posedge rst or negedge clk) begin
    if (!clk) begin
      busy_q    <= 1'b0;
      job_valid <= 1'b0;
    end else begin
      job_valid <= accept;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (done) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge rst) begin
    if (accept) begin
      job.rw        <= cmd.rw;
      job.addr_byte <= {cmd.dev_addr, cmd.rw};
      job.nbytes    <= nb;
      job.wbytes    <= cmd.wdata << shift;  // unused high bytes fall off the top
    end
  end

  // the engine would lose a job that arrives on the heels of another one
  a_job_single: assert property (@(posedge rst) disable iff (!clk) job_valid |=> !job_valid);

endmodule

/* design/i2c_bit_engine.sv */
`timescale 1ns/1ns
`include "i2c_cfg.svh"

module i2c_bit_engine import i2c_pkg::*; (
  input  logic          rst,
  input  logic          clk,
  input  logic          job_valid,
  input  i2c_job_t      job,
  output logic          scl,
  input  logic          sda_in,
  output logic          sda_low,
  output logic          evt_valid,
  output i2c_byte_evt_t evt
);

  localparam int QW = $clog2(`I2C_CLK_DIV + 1);

  typedef enum logic [2:0] {PH_IDLE, PH_START, PH_LOW, PH_HIGH, PH_STOP} phase_e;
  typedef enum logic [2:0] {
    BS_IDLE, BS_ADDR, BS_ACK_RX, BS_WRITE, BS_READ, BS_ACK_TX, BS_STOP
  } byte_e;

  phase_e                 ph;
  byte_e                  bs;
  logic [QW-1:0]          qdiv;
  logic [1:0]             qcnt;
  logic                   tick;
  logic                   start_pt, setup_pt, sample_pt, bit_end;
  logic                   stop_low_pt, stop_rel_pt, stop_end;
  logic                   go_stop, last_byte;
  logic [2:0]             bit_cnt, byte_cnt, nbytes_q;
  logic                   rw_q, addr_done, sda_smp;
  logic [7:0]             shreg;
  logic [`I2C_DATA_W-1:0] wbuf;

  assign tick        = (ph != PH_IDLE) && (qdiv == QW'(`I2C_CLK_DIV - 1));
  assign start_pt    = tick && ph == PH_START && qcnt == 2'd0;
  assign setup_pt    = tick && ph == PH_LOW && qcnt == 2'd0;   // middle of SCL low
  assign sample_pt   = tick && ph == PH_LOW && qcnt == 2'd1;   // SCL about to rise
  assign bit_end     = tick && ph == PH_HIGH && qcnt == 2'd1;
  assign stop_low_pt = tick && ph == PH_STOP && qcnt == 2'd0;
  assign stop_rel_pt = tick && ph == PH_STOP && qcnt == 2'd2;
  assign stop_end    = tick && ph == PH_STOP && qcnt == 2'd3;
  assign last_byte   = (byte_cnt + 3'd1 == nbytes_q);
  assign go_stop     = (bs == BS_ACK_RX && (sda_smp || (addr_done && last_byte))) ||
                       (bs == BS_ACK_TX && last_byte);

  // each SCL level lasts two quarters, START and STOP get their own quarter sequences
  always_ff @(posedge rst or negedge clk) begin
    if (!clk) begin
      ph   <= PH_IDLE;
      qdiv <= '0;
      qcnt <= '0;
      scl  <= 1'b1;
    end else if (ph == PH_IDLE) begin
      qdiv <= '0;
      qcnt <= '0;
      scl  <= 1'b1;
      if (job_valid) ph <= PH_START;
    end else begin
      qdiv <= tick ? '0 : qdiv + 1'b1;
      if (tick) begin
        qcnt <= qcnt + 2'd1;
        case (ph)
          PH_START: if (qcnt == 2'd1) begin
            ph   <= PH_LOW;
            scl  <= 1'b0;
            qcnt <= '0;
          end
          PH_LOW: if (qcnt == 2'd1) begin
            ph   <= PH_HIGH;
            scl  <= 1'b1;
            qcnt <= '0;
          end
          PH_HIGH: if (qcnt == 2'd1) begin
            ph   <= go_stop ? PH_STOP : PH_LOW;
            scl  <= 1'b0;
            qcnt <= '0;
          end
          PH_STOP: begin
            if (qcnt == 2'd1) scl <= 1'b1;
            if (qcnt == 2'd3) ph <= PH_IDLE;
          end
          default: ph <= PH_IDLE;
        endcase
      end
    end
  end

  always_ff @(posedge rst or negedge clk) begin
    if (!clk) begin
      bs        <= BS_IDLE;
      bit_cnt   <= '0;
      byte_cnt  <= '0;
      nbytes_q  <= '0;
      rw_q      <= 1'b0;
      addr_done <= 1'b0;
      sda_smp   <= 1'b0;
      shreg     <= '0;
      wbuf      <= '0;
      sda_low   <= 1'b0;
      evt_valid <= 1'b0;
      evt       <= '0;
    end else begin
      evt_valid <= 1'b0;
      if (job_valid && bs == BS_IDLE) begin
        bs        <= BS_ADDR;
        shreg     <= job.addr_byte;
        wbuf      <= job.wbytes;
        rw_q      <= job.rw;
        nbytes_q  <= job.nbytes;
        bit_cnt   <= '0;
        byte_cnt  <= '0;
        addr_done <= 1'b0;
      end
      if (start_pt || stop_low_pt) sda_low <= 1'b1;
      if (stop_rel_pt) sda_low <= 1'b0;  // SDA rises with SCL high, which is the STOP
      if (stop_end) begin
        bs        <= BS_IDLE;
        evt_valid <= 1'b1;
        evt       <= '{data: 8'h00, last: 1'b1, nack: 1'b0, is_read: 1'b0, stop_done: 1'b1};
      end
      if (setup_pt) begin
        case (bs)
          BS_ADDR, BS_WRITE: begin
            sda_low <= ~shreg[7];
            shreg   <= {shreg[6:0], shreg[7]};  // rotate so the byte is intact after 8 bits
          end
          BS_ACK_TX: sda_low <= ~last_byte;     // the final read byte gets a NACK
          default:   sda_low <= 1'b0;
        endcase
      end
      if (sample_pt) begin
        sda_smp <= sda_in;
        if (bs == BS_READ) shreg <= {shreg[6:0], sda_in};
      end
      if (bit_end) begin
        case (bs)
          BS_ADDR, BS_WRITE: begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) bs <= BS_ACK_RX;
          end
          BS_READ: begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) bs <= BS_ACK_TX;
          end
          BS_ACK_RX: begin
            evt_valid <= 1'b1;
            evt       <= '{data: shreg, last: go_stop, nack: sda_smp, is_read: 1'b0,
                           stop_done: 1'b0};
            addr_done <= 1'b1;
            if (addr_done) byte_cnt <= byte_cnt + 3'd1;
            if (go_stop) begin
              bs <= BS_STOP;
            end else if (rw_q && !addr_done) begin
              bs <= BS_READ;
            end else begin
              bs    <= BS_WRITE;
              shreg <= wbuf[`I2C_DATA_W-1 -: 8];
              wbuf  <= {wbuf[`I2C_DATA_W-9:0], 8'h00};
            end
          end
          BS_ACK_TX: begin
            evt_valid <= 1'b1;
            evt       <= '{data: shreg, last: last_byte, nack: 1'b0, is_read: 1'b1,
                           stop_done: 1'b0};
            byte_cnt  <= byte_cnt + 3'd1;
            bs        <= go_stop ? BS_STOP : BS_READ;
          end
          default: ;
        endcase
      end
    end
  end

  a_idle_release: assert property (@(posedge rst) disable iff (!clk)
    (ph == PH_IDLE) |-> !sda_low);

  // outside START and STOP the data line may only move while SCL is low
  a_sda_stable: assert property (@(posedge rst) disable iff (!clk)
    (scl && $past(scl) && ph != PH_START && ph != PH_STOP) |-> $stable(sda_low));

endmodule

/* design/i2c_read_collect.sv */
`timescale 1ns/1ns
`include "i2c_cfg.svh"

module i2c_read_collect import i2c_pkg::*; (
  input  logic          rst,
  input  logic          clk,
  input  logic          evt_valid,
  input  i2c_byte_evt_t evt,
  output logic          done,
  output i2c_result_t   result
);

  logic                   in_txn;
  logic                   nack_q;
  logic                   first;
  logic                   nack_nxt;
  logic [`I2C_DATA_W-1:0] acc, acc_base, acc_nxt;

  assign first    = evt_valid && !in_txn;  // address byte opens every transaction
  assign acc_base = first ? '0 : acc;
  // read bytes enter at the bottom so the first one ends up most significant
  assign acc_nxt  = evt.is_read ? {acc_base[`I2C_DATA_W-9:0], evt.data} : acc_base;
  assign nack_nxt = (!first && nack_q) | evt.nack;

  always_ff @(posedge rst or negedge clk) begin
    if (!clk) begin
      in_txn <= 1'b0;
      nack_q <= 1'b0;
      done   <= 1'b0;
    end else begin
      done <= evt_valid && evt.stop_done;
      if (evt_valid) begin
        in_txn <= !evt.stop_done;
        nack_q <= nack_nxt;
      end
    end
  end

  always_ff @(posedge rst) begin
    if (evt_valid) acc <= acc_nxt;
    if (evt_valid && evt.stop_done) begin
      result.rdata <= nack_nxt ? '0 : acc_nxt;  // a refused transfer returns no data
      result.nack  <= nack_nxt;
    end
  end

  a_done_pulse: assert property (@(posedge rst) disable iff (!clk) done |=> !done);

endmodule

/* design/i2c_master_top.sv */
`timescale 1ns/1ns

module i2c_master_top import i2c_pkg::*; (
  input  logic        rst,
  input  logic        clk,
  input  logic        start,
  input  i2c_cmd_t    cmd,
  output logic        busy,
  output logic        done,
  output i2c_result_t result,
  output logic        scl,
  inout  wire         sda
);

  logic          job_valid;
  i2c_job_t      job;
  logic          sda_low;
  logic          evt_valid;
  i2c_byte_evt_t evt;

  i2c_cmd_decode u_decode (
    .rst       (rst),
    .clk       (clk),
    .start     (start),
    .cmd       (cmd),
    .done      (done),
    .busy      (busy),
    .job_valid (job_valid),
    .job       (job)
  );

  i2c_bit_engine u_engine (
    .rst       (rst),
    .clk       (clk),
    .job_valid (job_valid),
    .job       (job),
    .scl       (scl),
    .sda_in    (sda),
    .sda_low   (sda_low),
    .evt_valid (evt_valid),
    .evt       (evt)
  );

  i2c_read_collect u_collect (
    .rst       (rst),
    .clk       (clk),
    .evt_valid (evt_valid),
    .evt       (evt),
    .done      (done),
    .result    (result)
  );

  // open drain, the pullup outside the chip supplies the high level
  assign sda = sda_low ? 1'b0 : 1'bz;

endmodule

/* verification/i2c_slave_model.sv */
`timescale 1ns/1ns

module i2c_slave_model #(
  parameter logic [6:0] ADDR = 7'h2A
) (
  input logic scl,
  inout wire  sda,
  input logic reset
);

  typedef enum logic [2:0] {S_IDLE, S_ADDR, S_ACK, S_WDATA, S_RDATA, S_RACK} state_e;

  logic [7:0] regs [0:3];
  state_e     st;
  logic [3:0] cnt;
  logic [7:0] shreg;
  logic [2:0] idx;
  logic       matched;
  logic       rw;
  logic       drv;

  assign sda = drv ? 1'b0 : 1'bz;

  initial begin
    st      = S_IDLE;
    cnt     = '0;
    shreg   = '0;
    idx     = '0;
    matched = 1'b0;
    rw      = 1'b0;
    drv     = 1'b0;
    for (int k = 0; k < 4; k++) regs[k] = 8'h00;
  end

  always @(posedge reset) begin
    st  = S_IDLE;
    drv = 1'b0;
  end

  // START and STOP are SDA edges while SCL is high
  always @(negedge sda) if (scl === 1'b1 && !reset) begin
    st  = S_ADDR;
    cnt = '0;
    idx = '0;
    drv = 1'b0;
  end

  always @(posedge sda) if (scl === 1'b1 && !reset) begin
    st  = S_IDLE;
    drv = 1'b0;
  end

  always @(posedge scl) if (!reset) begin
    case (st)
      S_ADDR, S_WDATA: begin
        shreg = {shreg[6:0], sda !== 1'b0};
        cnt   = cnt + 4'd1;
        if (cnt == 4'd8) begin
          if (st == S_ADDR) begin
            matched = (shreg[7:1] == ADDR);
            rw      = shreg[0];
          end else if (idx < 3'd4) begin
            regs[idx[1:0]] = shreg;  // bytes land in order from the first register
            idx            = idx + 3'd1;
          end
          st = S_ACK;
        end
      end
      S_ACK: begin
        cnt = '0;
        if (!matched) st = S_IDLE;
        else if (rw) st = S_RDATA;
        else st = S_WDATA;
      end
      S_RDATA: begin
        cnt = cnt + 4'd1;
        if (cnt == 4'd8) st = S_RACK;
      end
      S_RACK: begin
        if (sda === 1'b0) begin
          idx = idx + 3'd1;
          cnt = '0;
          st  = S_RDATA;
        end else begin
          st = S_IDLE;  // master NACK, the STOP follows
        end
      end
      default: ;
    endcase
  end

  // the slave only moves SDA just after SCL falls
  always @(negedge scl) if (!reset) begin
    case (st)
      S_ACK:   drv = matched;
      S_RDATA: drv = ~regs[idx[1:0]][3'd7 - cnt[2:0]];
      default: drv = 1'b0;
    endcase
  end

endmodule

/* verification/i2c_master_checker.sv */
`timescale 1ns/1ns
`include "i2c_cfg.svh"

module i2c_master_checker import i2c_pkg::*; #(
  parameter logic [6:0] SLAVE_ADDR = 7'h2A
) (
  input logic        rst,
  input logic        clk,
  input logic        start,
  input i2c_cmd_t    cmd,
  input logic        busy,
  input logic        done,
  input i2c_result_t result,
  input logic        scl,
  input wire         sda
);

  logic [7:0]  mirror [0:3];  // what the slave register should hold
  i2c_cmd_t    pend_cmd;
  i2c_result_t exp;
  logic        pending = 1'b0;
  logic        bus_active = 1'b0;
  logic        in_reset = 1'b0;  // reset was already low at the previous edge
  int          n_err = 0;
  int          n_start = 0;
  int          n_done = 0;
  int          n_abort = 0;
  int          n_check = 0;

  initial begin
    for (int k = 0; k < 4; k++) mirror[k] = 8'h00;
  end

  function automatic logic [2:0] clamp_count(logic [2:0] n);
    if (n == 3'd0) return 3'd1;
    if (n > 3'(`I2C_MAX_BYTES)) return 3'(`I2C_MAX_BYTES);
    return n;
  endfunction

  // first byte on the wire is the most significant of the low n bytes
  function automatic i2c_result_t expected_result(i2c_cmd_t c);
    i2c_result_t r;
    logic [2:0]  n;
    r = '0;
    n = clamp_count(c.nbytes);
    if (c.dev_addr != SLAVE_ADDR) begin
      r.nack = 1'b1;
      return r;
    end
    if (c.rw) begin
      for (int k = 0; k < n; k++) r.rdata = {r.rdata[23:0], mirror[k]};
    end
    return r;
  endfunction

  task automatic store_write(i2c_cmd_t c);
    logic [2:0] n;
    n = clamp_count(c.nbytes);
    for (int k = 0; k < n; k++) mirror[k] = c.wdata[8*(n-1-k) +: 8];
  endtask

  task automatic flag(string msg);
    $display("%0t: %s", $time, msg);
    n_err++;
  endtask

  always @(posedge rst) begin
    if (!clk) begin
      if (pending) n_abort++;
      pending = 1'b0;
      if (in_reset && (scl !== 1'b1 || sda !== 1'b1)) begin
        $display("CHECK FAILED scl/sda in reset expected 1/1 got %h/%h", scl, sda);
        n_err++;
      end
      in_reset = 1'b1;
    end else begin
      in_reset = 1'b0;
      if (done) begin
        n_done++;
        if (busy !== 1'b0) begin
          $display("CHECK FAILED busy in the done cycle expected 0 got %h", busy);
          n_err++;
        end
        if (!pending) begin
          flag("done pulsed without an accepted command");
        end else begin
          exp = expected_result(pend_cmd);
          n_check++;
          if (result !== exp) begin
            $display("CHECK FAILED result expected %h got %h", exp, result);
            n_err++;
          end
          if (!pend_cmd.rw && !exp.nack) store_write(pend_cmd);
          pending = 1'b0;
        end
      end else if (!busy && (scl !== 1'b1 || sda !== 1'b1)) begin
        $display("CHECK FAILED idle scl/sda expected 1/1 got %h/%h", scl, sda);
        n_err++;
      end
      if (start && !busy) begin
        pending  = 1'b1;
        pend_cmd = cmd;
        n_start++;
      end
    end
  end

  // a falling SDA with SCL high is only legal as START
  always @(negedge sda) if (clk && scl === 1'b1) begin
    if (bus_active) flag("SDA fell while SCL was high in the middle of a transfer");
    bus_active = 1'b1;
  end

  always @(posedge sda) if (clk && scl === 1'b1) bus_active = 1'b0;

  always @(negedge scl) if (clk && !bus_active) flag("SCL fell with no START on the bus");

  always @(negedge clk) bus_active = 1'b0;

endmodule

/* verification/i2c_master_tb.sv */
`timescale 1ns/1ns
`include "i2c_cfg.svh"

module i2c_master_tb import i2c_pkg::*; ();

  localparam int TXN_CYCLES  = (2 + 9 * (1 + `I2C_MAX_BYTES)) * 4 * `I2C_CLK_DIV;
  localparam int N_TXN       = 48;
  localparam int CYCLE_LIMIT = N_TXN * TXN_CYCLES * 2;

  logic        rst;
  logic        clk;
  logic        start;
  i2c_cmd_t    cmd;
  logic        busy;
  logic        done;
  i2c_result_t result;
  logic        scl;
  wire         sda;
  int          cycles = 0;
  int          tb_err = 0;
  int          mark;

  pullup (sda);

  i2c_master_top dut0 (
    .rst(rst), .clk(clk), .start(start), .cmd(cmd), .busy(busy),
    .done(done), .result(result), .scl(scl), .sda(sda)
  );

  i2c_slave_model #(.ADDR(7'h2A)) slave0 (.scl(scl), .sda(sda), .reset(!clk));

  i2c_master_checker #(.SLAVE_ADDR(7'h2A)) chk0 (
    .rst(rst), .clk(clk), .start(start), .cmd(cmd), .busy(busy),
    .done(done), .result(result), .scl(scl), .sda(sda)
  );

  initial begin
    rst = 1'b0;
    forever #4 rst = ~rst;
  end

  always @(posedge rst) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  function automatic int total_errors();
    return chk0.n_err + tb_err;
  endfunction

  task automatic issue(input logic rw, input logic [6:0] addr, input logic [2:0] n,
                       input logic [31:0] data);
    @(negedge rst);
    start = 1'b1;
    cmd   = '{rw: rw, dev_addr: addr, nbytes: n, wdata: data};
    @(negedge rst);
    start = 1'b0;
  endtask

  task automatic run_txn(input logic rw, input logic [6:0] addr, input logic [2:0] n,
                         input logic [31:0] data);
    issue(rw, addr, n, data);
    while (!done) @(negedge rst);
    @(negedge rst);
  endtask

  task automatic report_test(input string name);
    int e;
    e = total_errors() - mark;
    $display("test %s: %s (errors %0d)", name, (e == 0) ? "ok" : "bad", e);
    mark = total_errors();
  endtask

  initial begin
    logic [31:0] d;
    logic [2:0]  n;
    int          dones;
    void'($urandom(67));
    start = 1'b0;
    cmd   = '0;
    clk   = 1'b0;
    repeat (5) @(posedge rst);
    @(negedge rst);
    clk  = 1'b1;
    mark = 0;

    run_txn(1'b0, 7'h2A, 3'd4, 32'hA5C3_1E77);
    run_txn(1'b1, 7'h2A, 3'd4, 32'h0);
    report_test("1 four-byte write and read back");

    for (int i = 0; i < 20; i++) begin
      d = $urandom;
      n = 3'($urandom_range(1, 4));
      run_txn(1'b0, 7'h2A, n, d);
      run_txn(1'b1, 7'h2A, n, 32'h0);
    end
    report_test("2 random write/read pairs");

    run_txn(1'b1, 7'h15, 3'd2, 32'h0);
    run_txn(1'b0, 7'h51, 3'd3, 32'h0012_3456);
    if (busy !== 1'b0) begin
      $display("CHECK FAILED busy expected 0 got %h", busy);
      tb_err++;
    end
    report_test("3 wrong address");

    dones = chk0.n_done;
    issue(1'b0, 7'h2A, 3'd2, 32'h0000_BEEF);
    repeat (20) @(negedge rst);
    start = 1'b1;  // busy is high here, so this must be ignored
    cmd   = '{rw: 1'b1, dev_addr: 7'h2A, nbytes: 3'd1, wdata: 32'h0};
    @(negedge rst);
    start = 1'b0;
    while (!done) @(negedge rst);
    repeat (TXN_CYCLES) @(negedge rst);  // long enough for a stray job to finish
    if (chk0.n_done - dones != 1) begin
      $display("start while busy gave %0d done pulses instead of 1", chk0.n_done - dones);
      tb_err++;
    end
    report_test("4 start while busy");

    issue(1'b0, 7'h2A, 3'd4, 32'h1357_9BDF);
    repeat (150) @(negedge rst);
    clk = 1'b0;
    #1;
    if (busy !== 1'b0 || scl !== 1'b1 || sda !== 1'b1) begin
      $display("CHECK FAILED busy/scl/sda after reset expected 0/1/1 got %h/%h/%h",
               busy, scl, sda);
      tb_err++;
    end
    repeat (3) @(negedge rst);
    clk = 1'b1;
    run_txn(1'b0, 7'h2A, 3'd3, 32'h00C0_FFEE);
    run_txn(1'b1, 7'h2A, 3'd3, 32'h0);
    report_test("5 reset in mid-transaction");

    if (chk0.n_done + chk0.n_abort != chk0.n_start) begin
      $display("%0d done pulses and %0d aborted jobs do not match %0d accepted starts",
               chk0.n_done, chk0.n_abort, chk0.n_start);
      tb_err++;
    end
    $display("summary: %0d results checked, %0d starts, %0d dones, %0d errors",
             chk0.n_check, chk0.n_start, chk0.n_done, total_errors());
    if (total_errors() == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* i2c_master_top.f */
+incdir+include
design/i2c_pkg.sv
design/i2c_cmd_decode.sv
design/i2c_bit_engine.sv
design/i2c_read_collect.sv
design/i2c_master_top.sv
verification/i2c_slave_model.sv
verification/i2c_master_checker.sv
verification/i2c_master_tb.sv
